// ==== common/frame_sys_consts.svh ====
`ifndef FRAME_SYS_CONSTS_SVH
`define FRAME_SYS_CONSTS_SVH

// ========================================
// system memory geometry
// ========================================
`define SYS_ADDR_W 10 // word address bits, 1k words
`define SYS_DATA_W 32 // one bus word
`define SYS_MASK_W 4  // one enable per byte

// ========================================
// frame buffer and panel keys
// ========================================
`define FRAME_BASE 'h200     // first word of the frame
`define FRAME_WORDS 16       // two rgb565 pixels per word
`define FETCH_DEPTH 4        // stored plus in-flight words
`define DEBOUNCE_CYCLES 16   // stable cycles before a level is taken

`endif

// ==== common/sysmem_pkg.sv ====
`include "frame_sys_consts.svh"

package sysmem_pkg;

  // memory bus fields shared by every requester and the ram
  typedef logic [`SYS_ADDR_W-1:0] sys_addr_t; // word address
  typedef logic [`SYS_DATA_W-1:0] sys_data_t; // read or write word
  typedef logic [`SYS_MASK_W-1:0] sys_mask_t; // byte write enables

endpackage

// ==== common/display_pkg.sv ====
package display_pkg;

  // pixel as stored in the frame buffer, r5 g6 b5
  typedef logic [15:0] rgb565_t;

  // pixel as sent to the panel, r8 g8 b8
  typedef logic [23:0] rgb888_t;

endpackage

// ==== common/mem_req_if.sv ====
`timescale 1ns/10ps

interface mem_req_if
  import sysmem_pkg::*;
();

  logic      req_valid; // request present
  logic      req_ready; // arbiter takes it this cycle
  sys_addr_t req_addr;  // word address
  logic      req_write; // 1 write, 0 read
  sys_data_t req_wdata;
  sys_mask_t req_wmask;
  logic      rsp_valid; // read data, one cycle after transfer
  sys_data_t rsp_rdata;

  modport requester (
    output req_valid, req_addr, req_write, req_wdata, req_wmask,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport arbiter (
    input  req_valid, req_addr, req_write, req_wdata, req_wmask,
    output req_ready, rsp_valid, rsp_rdata
  );

  // ram side, always ready so no req_ready here
  modport target (
    input  req_valid, req_addr, req_write, req_wdata, req_wmask,
    output rsp_valid, rsp_rdata
  );

endinterface

// ==== verilog/key_debounce.sv ====
`timescale 1ns/10ps
`include "frame_sys_consts.svh"

module key_debounce #(
  parameter int STABLE_CYCLES = `DEBOUNCE_CYCLES
) (
  input  logic clk_8388,
  input  logic fpga_rst_n,
  input  logic i_button, // async pin, active low
  output logic o_press   // pulse on accepted 1 to 0
);

  localparam int CNT_W = $clog2(STABLE_CYCLES + 1);

  typedef enum logic {KEY_RELEASED, KEY_PRESSED} key_state_t;

  key_state_t       state_q;    // accepted level
  logic [1:0]       sync_q;     // two-flop synchronizer
  logic [CNT_W-1:0] stable_cnt; // cycles the input has differed
  logic             differ;
  logic             settle;

  assign differ = sync_q[1] != (state_q == KEY_RELEASED); // released means level 1
  assign settle = differ && (stable_cnt == CNT_W'(STABLE_CYCLES - 1));

  always_ff @(posedge clk_8388 or negedge fpga_rst_n) begin
    if (!fpga_rst_n) begin
      sync_q     <= 2'b11;        // button idles high
      state_q    <= KEY_RELEASED;
      stable_cnt <= '0;
      o_press    <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], i_button};
      o_press <= settle && (state_q == KEY_RELEASED); // only the press edge
      if (!differ || settle) begin
        stable_cnt <= '0;                             // bounce restarts the count
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
      if (settle) begin
        state_q <= (state_q == KEY_RELEASED) ? KEY_PRESSED : KEY_RELEASED;
      end
    end
  end

endmodule

// ==== verilog/panel_ctrl.sv ====
`timescale 1ns/10ps

module panel_ctrl (
  input  logic clk_8388,
  input  logic fpga_rst_n,
  input  logic i_key2,      // raw button, low when pressed
  input  logic i_key3,
  output logic o_lcd_rst,   // toggled by key2
  output logic o_stream_en  // toggled by key3
);

  logic key2_press; // one-cycle pulse per accepted press
  logic key3_press;

  key_debounce u_key2 (
    .clk_8388   (clk_8388),
    .fpga_rst_n (fpga_rst_n),
    .i_button   (i_key2),
    .o_press    (key2_press)
  );

  key_debounce u_key3 (
    .clk_8388   (clk_8388),
    .fpga_rst_n (fpga_rst_n),
    .i_button   (i_key3),
    .o_press    (key3_press)
  );

  // key2 wins when both land on the same cycle
  always_ff @(posedge clk_8388 or negedge fpga_rst_n) begin
    if (!fpga_rst_n) begin
      o_lcd_rst   <= 1'b0;                // panel held in reset
      o_stream_en <= 1'b0;                // video engine parked
    end else if (key2_press) begin
      o_lcd_rst   <= ~o_lcd_rst;
    end else if (key3_press) begin
      o_stream_en <= ~o_stream_en;
    end
  end

endmodule

// ==== sysmem/sysmem_ram.sv ====
`timescale 1ns/10ps
`include "frame_sys_consts.svh"

module sysmem_ram
  import sysmem_pkg::*;
(
  input logic       clk_8388,
  mem_req_if.target mem
);

  localparam int WORDS = 2 ** `SYS_ADDR_W;

  sys_data_t ram_q [WORDS]; // word array, no reset
  logic      rd_en;

  assign rd_en = mem.req_valid & ~mem.req_write;

  always_ff @(posedge clk_8388) begin
    if (mem.req_valid && mem.req_write) begin
      for (int b = 0; b < `SYS_MASK_W; b++) begin
        if (mem.req_wmask[b]) begin
          ram_q[mem.req_addr][b*8 +: 8] <= mem.req_wdata[b*8 +: 8]; // masked byte lane
        end
      end
    end
    mem.rsp_valid <= rd_en;                  // one-cycle read latency
    if (rd_en) begin
      mem.rsp_rdata <= ram_q[mem.req_addr];
    end
  end

endmodule

// ==== sysmem/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter (
  input logic          clk_8388,
  input logic          fpga_rst_n,
  mem_req_if.arbiter   cpu, // processor bus port
  mem_req_if.arbiter   vid, // video read engine
  mem_req_if.requester ram  // single word ram that is always ready
);

  logic grant_cpu;
  logic grant_vid;
  logic last_vid_q;  // video held the last grant
  logic owner_vid_q; // response in flight belongs to video

  // ========================================
  // round-robin pick, combinational
  // ========================================
  always_comb begin
    grant_vid = vid.req_valid && (!cpu.req_valid || !last_vid_q); // alternate on conflict
    grant_cpu = cpu.req_valid && !grant_vid;
  end

  assign cpu.req_ready = ~grant_vid; // lost only to a video grant
  assign vid.req_ready = ~grant_cpu;

  // steer the winner to the ram
  assign ram.req_valid = cpu.req_valid | vid.req_valid;
  assign ram.req_addr  = grant_vid ? vid.req_addr  : cpu.req_addr;
  assign ram.req_write = grant_vid ? vid.req_write : cpu.req_write;
  assign ram.req_wdata = grant_vid ? vid.req_wdata : cpu.req_wdata;
  assign ram.req_wmask = grant_vid ? vid.req_wmask : cpu.req_wmask;

  // ========================================
  // response routing
  // ========================================
  assign cpu.rsp_valid = ram.rsp_valid & ~owner_vid_q;
  assign vid.rsp_valid = ram.rsp_valid &  owner_vid_q;
  assign cpu.rsp_rdata = ram.rsp_rdata; // data fanned out while valid picks the peer
  assign vid.rsp_rdata = ram.rsp_rdata;

  always_ff @(posedge clk_8388 or negedge fpga_rst_n) begin
    if (!fpga_rst_n) begin
      last_vid_q  <= 1'b0; // video wins the first conflict
      owner_vid_q <= 1'b0;
    end else begin
      owner_vid_q <= grant_vid;   // ram answers exactly one cycle later
      if (ram.req_valid) begin
        last_vid_q <= grant_vid;
      end
    end
  end

endmodule

// ==== sysmem/cpu_bus_port.sv ====
`timescale 1ns/10ps

module cpu_bus_port
  import sysmem_pkg::*;
(
  input  logic      clk_8388,
  input  logic      fpga_rst_n,
  input  logic      i_cmd_valid,
  output logic      o_cmd_ready,
  input  sys_addr_t i_cmd_addr,
  input  logic      i_cmd_read,
  input  sys_data_t i_cmd_wdata,
  input  sys_mask_t i_cmd_wmask,
  output logic      o_rsp_valid,
  input  logic      i_rsp_ready,
  output sys_data_t o_rsp_rdata,
  mem_req_if.requester mem
);

  logic      busy_q;      // response slot taken
  logic      rd_wait_q;   // read data due this cycle
  logic      held_q;      // slot holds a registered response
  sys_data_t held_data_q;
  logic      cmd_fire;
  logic      rsp_fire;
  logic      rd_rsp;

  // commands pass straight through while the slot is free
  assign mem.req_valid = i_cmd_valid & ~busy_q;
  assign mem.req_addr  = i_cmd_addr;
  assign mem.req_write = ~i_cmd_read;
  assign mem.req_wdata = i_cmd_wdata;
  assign mem.req_wmask = i_cmd_wmask;
  assign o_cmd_ready   = ~busy_q & mem.req_ready;
  assign cmd_fire      = i_cmd_valid & o_cmd_ready;

  assign rd_rsp      = rd_wait_q & mem.rsp_valid;             // read data bypasses the slot
  assign o_rsp_valid = held_q | rd_rsp;
  assign o_rsp_rdata = held_q ? held_data_q : mem.rsp_rdata;
  assign rsp_fire    = o_rsp_valid & i_rsp_ready;

  always_ff @(posedge clk_8388 or negedge fpga_rst_n) begin
    if (!fpga_rst_n) begin
      busy_q    <= 1'b0;
      rd_wait_q <= 1'b0;
      held_q    <= 1'b0;
    end else begin
      rd_wait_q <= cmd_fire & i_cmd_read;
      if (cmd_fire) begin
        busy_q <= 1'b1;
      end else if (rsp_fire) begin
        busy_q <= 1'b0;                                        // slot free again
      end
      if (rsp_fire) begin
        held_q <= 1'b0;
      end else if ((cmd_fire && !i_cmd_read) || rd_rsp) begin
        held_q <= 1'b1;                                        // write ack or stalled read
      end
    end
  end

  always_ff @(posedge clk_8388) begin
    if (cmd_fire && !i_cmd_read) begin
      held_data_q <= '0;                                       // write ack carries zero
    end else if (rd_rsp) begin
      held_data_q <= mem.rsp_rdata;
    end
  end

endmodule

// ==== video/video_fetch.sv ====
`timescale 1ns/10ps
`include "frame_sys_consts.svh"

module video_fetch
  import sysmem_pkg::*;
  import display_pkg::*;
#(
  parameter int FRAME_WORDS_P = `FRAME_WORDS
) (
  input  logic         clk_8388,
  input  logic         fpga_rst_n,
  input  logic         i_stream_en, // gates new reads
  mem_req_if.requester mem,
  output logic         o_pix_valid,
  input  logic         i_pix_ready,
  output rgb888_t      o_pix_rgb,
  output logic         o_pix_sof    // first pixel of a frame
);

  localparam int DEPTH = `FETCH_DEPTH;              // power of two
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int IDX_W = (FRAME_WORDS_P > 1) ? $clog2(FRAME_WORDS_P) : 1;

  typedef enum logic {ST_IDLE, ST_FETCH} fetch_state_t;

  fetch_state_t     state_q;
  logic [IDX_W-1:0] rd_idx_q;   // next word within the frame
  logic [CNT_W-1:0] credit_q;   // stored plus in flight
  logic [CNT_W-1:0] word_cnt_q; // stored only
  logic [PTR_W-1:0] iss_ptr_q;  // slot reserved by the next read
  logic [PTR_W-1:0] wr_ptr_q;   // slot for the next returned word
  logic [PTR_W-1:0] rd_ptr_q;   // word being shown
  logic             half_q;     // 0 low pixel, 1 high pixel
  sys_data_t        word_q [DEPTH];
  logic [DEPTH-1:0] sof_q;      // word came from FRAME_BASE
  logic             issue;
  logic             pop_word;
  rgb565_t          pix565;

  // ========================================
  // read side
  // ========================================
  assign mem.req_valid = (state_q == ST_FETCH) && (credit_q < CNT_W'(DEPTH));
  assign mem.req_addr  = sys_addr_t'(`FRAME_BASE) + sys_addr_t'(rd_idx_q);
  assign mem.req_write = 1'b0;                       // read-only peer
  assign mem.req_wdata = '0;
  assign mem.req_wmask = '0;
  assign issue         = mem.req_valid & mem.req_ready;

  // ========================================
  // pixel side
  // ========================================
  assign o_pix_valid = (word_cnt_q != '0);
  assign pop_word    = o_pix_valid & i_pix_ready & half_q;  // word done after high half
  assign pix565      = half_q ? word_q[rd_ptr_q][31:16] : word_q[rd_ptr_q][15:0];
  assign o_pix_rgb   = {pix565[15:11], 3'b000, pix565[10:5], 2'b00, pix565[4:0], 3'b000};
  assign o_pix_sof   = o_pix_valid & sof_q[rd_ptr_q] & ~half_q;

  always_ff @(posedge clk_8388 or negedge fpga_rst_n) begin
    if (!fpga_rst_n) begin
      state_q    <= ST_IDLE;
      rd_idx_q   <= '0;
      credit_q   <= '0;
      word_cnt_q <= '0;
      iss_ptr_q  <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      half_q     <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_stream_en) begin
            state_q <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (!i_stream_en && !(mem.req_valid && !mem.req_ready)) begin
            state_q <= ST_IDLE;                      // never drop a pending request
          end
        end
        default: state_q <= ST_IDLE;
      endcase
      if (issue) begin
        rd_idx_q <= (rd_idx_q == IDX_W'(FRAME_WORDS_P - 1)) ? '0 : rd_idx_q + 1'b1;
      end else if (state_q == ST_IDLE) begin
        rd_idx_q <= '0;                              // next enable starts a frame
      end
      credit_q   <= credit_q + CNT_W'(issue) - CNT_W'(pop_word);
      word_cnt_q <= word_cnt_q + CNT_W'(mem.rsp_valid) - CNT_W'(pop_word);
      iss_ptr_q  <= iss_ptr_q + PTR_W'(issue);
      wr_ptr_q   <= wr_ptr_q + PTR_W'(mem.rsp_valid);
      rd_ptr_q   <= rd_ptr_q + PTR_W'(pop_word);
      if (o_pix_valid && i_pix_ready) begin
        half_q <= ~half_q;
      end
    end
  end

  // words return in issue order, so the tag slot matches the data slot
  always_ff @(posedge clk_8388) begin
    if (issue) begin
      sof_q[iss_ptr_q] <= (rd_idx_q == '0);
    end
    if (mem.rsp_valid) begin
      word_q[wr_ptr_q] <= mem.rsp_rdata;
    end
  end

endmodule

// ==== verilog/frame_sys_top.sv ====
`timescale 1ns/10ps

module frame_sys_top
  import sysmem_pkg::*;
  import display_pkg::*;
(
  input  logic      clk_8388,
  input  logic      fpga_rst_n,  // async, active low
  input  logic      i_key2,      // lcd reset toggle, low when pressed
  input  logic      i_key3,      // stream enable toggle
  input  logic      i_cmd_valid, // cpu command channel
  output logic      o_cmd_ready,
  input  sys_addr_t i_cmd_addr,
  input  logic      i_cmd_read,
  input  sys_data_t i_cmd_wdata,
  input  sys_mask_t i_cmd_wmask,
  output logic      o_rsp_valid, // cpu response channel
  input  logic      i_rsp_ready,
  output sys_data_t o_rsp_rdata,
  output logic      o_pix_valid, // pixel stream
  input  logic      i_pix_ready,
  output rgb888_t   o_pix_rgb,
  output logic      o_pix_sof,
  output logic      o_lcd_rst,
  output logic      o_stream_en
);

  mem_req_if cpu_ch (); // cpu port to arbiter
  mem_req_if vid_ch (); // video engine to arbiter
  mem_req_if ram_ch (); // arbiter to ram

  // ========================================
  // panel keys
  // ========================================
  panel_ctrl u_panel_ctrl (
    .clk_8388    (clk_8388),
    .fpga_rst_n  (fpga_rst_n),
    .i_key2      (i_key2),
    .i_key3      (i_key3),
    .o_lcd_rst   (o_lcd_rst),
    .o_stream_en (o_stream_en)
  );

  // ========================================
  // system memory and its two peers
  // ========================================
  cpu_bus_port u_cpu_bus_port (
    .clk_8388    (clk_8388),
    .fpga_rst_n  (fpga_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .o_cmd_ready (o_cmd_ready),
    .i_cmd_addr  (i_cmd_addr),
    .i_cmd_read  (i_cmd_read),
    .i_cmd_wdata (i_cmd_wdata),
    .i_cmd_wmask (i_cmd_wmask),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_rdata (o_rsp_rdata),
    .mem         (cpu_ch.requester)
  );

  video_fetch u_video_fetch (
    .clk_8388    (clk_8388),
    .fpga_rst_n  (fpga_rst_n),
    .i_stream_en (o_stream_en), // flag gates the engine
    .mem         (vid_ch.requester),
    .o_pix_valid (o_pix_valid),
    .i_pix_ready (i_pix_ready),
    .o_pix_rgb   (o_pix_rgb),
    .o_pix_sof   (o_pix_sof)
  );

  mem_arbiter u_mem_arbiter (
    .clk_8388   (clk_8388),
    .fpga_rst_n (fpga_rst_n),
    .cpu        (cpu_ch.arbiter),
    .vid        (vid_ch.arbiter),
    .ram        (ram_ch.requester)
  );

  sysmem_ram u_sysmem_ram (
    .clk_8388 (clk_8388),
    .mem      (ram_ch.target)
  );

endmodule

// ==== test/frame_sys_tb.sv ====
`timescale 1ns/10ps
`include "frame_sys_consts.svh"

module frame_sys_tb
  import sysmem_pkg::*;
  import display_pkg::*;
();

  localparam int CLK_PERIOD     = 40;
  localparam int RST_CYCLES     = 10;
  localparam int CYCLES_PER_OP  = 400; // watchdog budget per data line
  localparam int MAX_PIX        = 64;

  logic      clk_8388;
  logic      fpga_rst_n;
  logic      i_key2;
  logic      i_key3;
  logic      i_cmd_valid;
  logic      o_cmd_ready;
  sys_addr_t i_cmd_addr;
  logic      i_cmd_read;
  sys_data_t i_cmd_wdata;
  sys_mask_t i_cmd_wmask;
  logic      o_rsp_valid;
  logic      i_rsp_ready;
  sys_data_t o_rsp_rdata;
  logic      o_pix_valid;
  logic      i_pix_ready;
  rgb888_t   o_pix_rgb;
  logic      o_pix_sof;
  logic      o_lcd_rst;
  logic      o_stream_en;

  integer      seed;          // shared by both ready lines
  logic [7:0]  op_kind [$];   // W, R or K
  logic [31:0] op_f1 [$];
  logic [31:0] op_f2 [$];
  logic [31:0] op_f3 [$];
  rgb888_t     exp_rgb [MAX_PIX];
  logic        exp_sof [MAX_PIX];
  sys_data_t   exp_rsp_q [$]; // one entry per accepted command
  int          num_p;
  int          p_lines;
  int          n_lines;
  int          pix_count;
  logic        keys_started;  // first key op begun
  logic        run_ready;     // reset released
  logic        loaded;
  logic        exp_lcd_rst;
  logic        exp_stream_en;

  frame_sys_top DUT (
    .clk_8388    (clk_8388),
    .fpga_rst_n  (fpga_rst_n),
    .i_key2      (i_key2),
    .i_key3      (i_key3),
    .i_cmd_valid (i_cmd_valid),
    .o_cmd_ready (o_cmd_ready),
    .i_cmd_addr  (i_cmd_addr),
    .i_cmd_read  (i_cmd_read),
    .i_cmd_wdata (i_cmd_wdata),
    .i_cmd_wmask (i_cmd_wmask),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_rdata (o_rsp_rdata),
    .o_pix_valid (o_pix_valid),
    .i_pix_ready (i_pix_ready),
    .o_pix_rgb   (o_pix_rgb),
    .o_pix_sof   (o_pix_sof),
    .o_lcd_rst   (o_lcd_rst),
    .o_stream_en (o_stream_en)
  );

  initial begin
    clk_8388 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_8388 = ~clk_8388;
  end

  // ========================================
  // helpers
  // ========================================
  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string sig, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR: time %0t signal %s expected %h actual %h",
               $time, sig, expected, actual);
      abort_run();
    end
  endtask

  task automatic load_tests(output string err);
    integer             fd;
    integer             code;
    logic [7:0]         op;
    logic [31:0]        f1;
    logic [31:0]        f2;
    logic [31:0]        f3;
    logic [8*160-1:0]   rest_line;
    err = "";
    fd  = $fopen("test/frame_sys_tests.txt", "r");
    if (fd == 0) begin
      err = "cannot open test/frame_sys_tests.txt";
    end else begin
      code = $fscanf(fd, " %c", op);
      while (code == 1 && err.len() == 0) begin
        if (op == "#") begin
          code = $fgets(rest_line, fd);          // column notes
        end else if (op == "W" || op == "R" || op == "K") begin
          if (op == "W") code = $fscanf(fd, "%h %h %h", f1, f2, f3);
          else if (op == "R") code = $fscanf(fd, "%h %h", f1, f2) + 1;
          else code = $fscanf(fd, "%d %d", f1, f2) + 1;
          if (code != 3) err = "malformed W, R or K line in data file";
          else if (op == "K" && f1 != 2 && f1 != 3) err = "key number is not 2 or 3";
          else if (op == "K" && f2 >= `DEBOUNCE_CYCLES && f2 <= `DEBOUNCE_CYCLES + 2)
            err = "key hold length sits on the debounce limit";
          op_kind.push_back(op);
          op_f1.push_back(f1);
          op_f2.push_back(f2);
          op_f3.push_back(f3);
          n_lines++;
        end else if (op == "P") begin
          code = $fscanf(fd, "%d %h %d", f1, f2, f3);
          if (code != 3 || f1 >= MAX_PIX) begin
            err = "malformed P line in data file";
          end else begin
            exp_rgb[f1] = f2[23:0];
            exp_sof[f1] = f3[0];
            p_lines++;
            if (f1 + 1 > num_p) num_p = f1 + 1;
            n_lines++;
          end
        end else begin
          err = "unknown opcode in data file";
        end
        code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
      if (err.len() == 0 && num_p != p_lines) err = "P indices are not contiguous from 0";
    end
  endtask

  // one command held until the port takes it
  task automatic send_cmd(input logic is_read, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] mask,
                          input logic [31:0] exp_data);
    logic accepted;
    accepted    = 1'b0;
    i_cmd_valid = 1'b1;
    i_cmd_read  = is_read;
    i_cmd_addr  = sys_addr_t'(addr);
    i_cmd_wdata = wdata;
    i_cmd_wmask = sys_mask_t'(mask);
    while (!accepted) begin
      #(CLK_PERIOD / 4);                        // mid low phase
      if (o_cmd_ready) begin
        accepted = 1'b1;
        exp_rsp_q.push_back(is_read ? sys_data_t'(exp_data) : sys_data_t'(0));
      end
      @(negedge clk_8388);
    end
    i_cmd_valid = 1'b0;
  endtask

  // hold a key low, release, let the release settle, then check both flags
  task automatic press_key(input logic [31:0] key, input logic [31:0] hold);
    keys_started = 1'b1;
    if (key == 2) i_key2 = 1'b0;
    else i_key3 = 1'b0;
    repeat (hold) @(negedge clk_8388);
    i_key2 = 1'b1;
    i_key3 = 1'b1;
    repeat (`DEBOUNCE_CYCLES + 6) @(negedge clk_8388);
    if (hold > `DEBOUNCE_CYCLES + 2) begin      // long hold toggles
      if (key == 2) exp_lcd_rst = ~exp_lcd_rst;
      else exp_stream_en = ~exp_stream_en;
    end
    check_equal("o_lcd_rst", exp_lcd_rst, o_lcd_rst);
    check_equal("o_stream_en", exp_stream_en, o_stream_en);
  endtask

  task automatic run_ops();
    for (int i = 0; i < op_kind.size(); i++) begin
      case (op_kind[i])
        "W": send_cmd(1'b0, op_f1[i], op_f2[i], op_f3[i], 32'h0);
        "R": send_cmd(1'b1, op_f1[i], 32'h0, 32'h0, op_f2[i]);
        "K": press_key(op_f1[i], op_f2[i]);
        default: ;
      endcase
    end
  endtask

  // ========================================
  // main flow
  // ========================================
  initial begin : main_flow
    string load_err;
    fpga_rst_n    = 1'b0;
    i_key2        = 1'b1;                       // keys idle released
    i_key3        = 1'b1;
    i_cmd_valid   = 1'b0;
    i_cmd_addr    = '0;
    i_cmd_read    = 1'b0;
    i_cmd_wdata   = '0;
    i_cmd_wmask   = '0;
    i_rsp_ready   = 1'b0;
    i_pix_ready   = 1'b0;
    seed          = 32'h2363_f282;
    num_p         = 0;
    p_lines       = 0;
    n_lines       = 0;
    pix_count     = 0;
    keys_started  = 1'b0;
    run_ready     = 1'b0;
    loaded        = 1'b0;
    exp_lcd_rst   = 1'b0;
    exp_stream_en = 1'b0;
    load_tests(load_err);
    if (load_err.len() != 0) begin
      $display("%s", load_err);
      abort_run();
    end else begin
      loaded = 1'b1;
      repeat (RST_CYCLES) @(negedge clk_8388);
      fpga_rst_n = 1'b1;
      run_ready  = 1'b1;
      run_ops();
      while (exp_rsp_q.size() != 0 || pix_count < num_p) @(negedge clk_8388);
      repeat (4) @(negedge clk_8388);           // a stray response would still be up
      if (o_rsp_valid === 1'b0) begin
        $display("All tests passed!");
        $finish;
      end else begin
        check_equal("o_rsp_valid", 32'h0, o_rsp_valid);
      end
    end
  end

  // ========================================
  // response and pixel monitor
  // ========================================
  initial begin : stream_monitor
    logic [31:0] r;
    sys_data_t   exp_data;
    wait (run_ready);
    forever begin
      @(negedge clk_8388);
      r           = $random(seed);
      i_rsp_ready = (r[1:0] != 2'b00);          // ready about 3 of 4 cycles
      i_pix_ready = (r[3:2] != 2'b00);
      if (!keys_started) begin
        check_equal("o_stream_en", 32'h0, o_stream_en);
        check_equal("o_lcd_rst", 32'h0, o_lcd_rst);
        check_equal("o_pix_valid", 32'h0, o_pix_valid);
      end
      if (o_rsp_valid && i_rsp_ready) begin     // transfers at next rising edge
        if (exp_rsp_q.size() == 0) begin
          $display("response seen with no command outstanding");
          abort_run();
        end else begin
          exp_data = exp_rsp_q.pop_front();
          check_equal("o_rsp_rdata", exp_data, o_rsp_rdata);
        end
      end
      if (o_pix_valid && i_pix_ready && pix_count < num_p) begin
        check_equal("o_pix_rgb", exp_rgb[pix_count], o_pix_rgb);
        check_equal("o_pix_sof", exp_sof[pix_count], o_pix_sof);
        pix_count++;
      end
    end
  end

  // watchdog budget scales with the data file
  initial begin : watchdog
    wait (loaded);
    repeat (n_lines * CYCLES_PER_OP) @(posedge clk_8388);
    $display("timeout after %0d cycles, run did not finish", n_lines * CYCLES_PER_OP);
    abort_run();
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/sysmem_pkg.sv
common/display_pkg.sv
common/mem_req_if.sv
verilog/key_debounce.sv
verilog/panel_ctrl.sv
sysmem/sysmem_ram.sv
sysmem/mem_arbiter.sv
sysmem/cpu_bus_port.sv
video/video_fetch.sv
verilog/frame_sys_top.sv
test/frame_sys_tb.sv

// ==== test/frame_sys_tests.txt ====
# W addr data mask | R addr expected_data | K key hold_cycles | P index rgb888 sof
# addr, data, mask and rgb888 are hex; key, hold_cycles, index and sof are decimal
W 200 0c3e041f f
W 201 1c7c145d f
W 202 2cba249b f
W 203 3cf834d9 f
W 204 4d364517 f
W 205 5d745555 f
W 206 6db26593 f
W 207 7df075d1 f
W 208 8e2e860f f
W 209 9e6c964d f
W 20a aeaaa68b f
W 20b bee8b6c9 f
W 20c cf26c707 f
W 20d df64d745 f
W 20e efa2e783 f
W 20f ffe0f7c1 f
W 010 11223344 f
W 010 aabbccdd 5
R 010 11bb33dd
W 011 deadbeef f
W 011 00000000 8
R 011 00adbeef
W 012 cafef00d f
W 012 ffffffff 0
R 012 cafef00d
R 205 5d745555
K 3 5
K 2 24
K 3 24
R 010 11bb33dd
R 011 00adbeef
W 013 12345678 f
R 013 12345678
R 012 cafef00d
P 0 0080f8 1
P 1 0884f0 0
P 2 1088e8 0
P 3 188ce0 0
P 4 2090d8 0
P 5 2894d0 0
P 6 3098c8 0
P 7 389cc0 0
P 8 40a0b8 0
P 9 48a4b0 0
P 10 50a8a8 0
P 11 58aca0 0
P 12 60b098 0
P 13 68b490 0
P 14 70b888 0
P 15 78bc80 0
P 16 80c078 0
P 17 88c470 0
P 18 90c868 0
P 19 98cc60 0
P 20 a0d058 0
P 21 a8d450 0
P 22 b0d848 0
P 23 b8dc40 0
P 24 c0e038 0
P 25 c8e430 0
P 26 d0e828 0
P 27 d8ec20 0
P 28 e0f018 0
P 29 e8f410 0
P 30 f0f808 0
P 31 f8fc00 0
P 32 0080f8 1
